// ==== logic/event_builder_settings.svh ====
`ifndef EVENT_BUILDER_SETTINGS_SVH
`define EVENT_BUILDER_SETTINGS_SVH

// number of incoming link streams
`define EB_NUM_LINKS 4

// width of link words and of the output stream
`define EB_DATA_W 32

// words reserved per link in the shared buffer
`define EB_REGION_DEPTH 64

// buffer address, link number on top of the region offset
`define EB_ADDR_W 8

// event number field in the header word
`define EB_EVNUM_W 16

`endif

// ==== logic/event_builder_pkg.sv ====
`include "event_builder_settings.svh"

package event_builder_pkg;

    typedef logic [`EB_DATA_W-1:0] data_t;

    // region base is link number times region depth
    typedef logic [`EB_ADDR_W-1:0] buf_addr_t;

    // needs one extra bit to hold a full region
    typedef logic [$clog2(`EB_REGION_DEPTH):0] word_count_t;

    typedef logic [`EB_NUM_LINKS-1:0] link_mask_t;
    typedef logic [$clog2(`EB_NUM_LINKS)-1:0] link_id_t;
    typedef logic [`EB_EVNUM_W-1:0] evnum_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_HOLD,
        WR_DONE
    } writer_state_t;

    typedef enum logic [2:0] {
        RO_WAIT,
        RO_HEADER,
        RO_REQUEST,
        RO_STREAM,
        RO_RELEASE
    } readout_state_t;

endpackage

// ==== logic/link_event_writer.sv ====
`timescale 1ns/1ns
`include "event_builder_settings.svh"

module link_event_writer
    import event_builder_pkg::*;
#(
    parameter int LINK_ID = 0
) (
    input  logic        aclk,
    input  logic        rst_n_i,
    input  logic        event_open_i,
    input  data_t       s_tdata_i,
    input  logic        s_tvalid_i,
    input  logic        s_tlast_i,
    output logic        s_tready_o,
    output logic        wr_req_o,
    output buf_addr_t   wr_addr_o,
    output data_t       wr_data_o,
    input  logic        wr_gnt_i,
    input  logic        release_i,
    output logic        done_o,
    output word_count_t count_o,
    output logic        overflow_o
);

    localparam buf_addr_t   REGION_BASE = buf_addr_t'(LINK_ID * `EB_REGION_DEPTH);
    localparam word_count_t DEPTH       = word_count_t'(`EB_REGION_DEPTH);

    writer_state_t state_q;
    word_count_t   count_q;
    logic          overflow_q;
    data_t         data_q;
    logic          last_q;
    logic          accept;

    // a closed interface swallows everything the link offers
    assign s_tready_o = !event_open_i || (state_q == WR_IDLE);
    assign accept     = event_open_i && s_tvalid_i && (state_q == WR_IDLE);

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= WR_IDLE;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (accept) begin
                        if (count_q == DEPTH) begin
                            // region full, word is dropped
                            overflow_q <= 1'b1;
                            if (s_tlast_i) begin
                                state_q <= WR_DONE;
                            end
                        end else begin
                            state_q <= WR_HOLD;
                        end
                    end
                end
                WR_HOLD: begin
                    if (wr_gnt_i) begin
                        count_q <= count_q + 1'b1;
                        state_q <= last_q ? WR_DONE : WR_IDLE;
                    end
                end
                WR_DONE: begin
                    if (release_i) begin
                        count_q <= '0;
                        state_q <= WR_IDLE;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    // captured word waits here until the arbiter takes it
    always_ff @(posedge aclk) begin
        if (accept) begin
            data_q <= s_tdata_i;
            last_q <= s_tlast_i;
        end
    end

    assign wr_req_o   = (state_q == WR_HOLD);
    assign wr_addr_o  = REGION_BASE + buf_addr_t'(count_q);
    assign wr_data_o  = data_q;
    assign done_o     = (state_q == WR_DONE);
    assign count_o    = count_q;
    assign overflow_o = overflow_q;

    // a request past the region end would spill into the next link's region
    a_no_req_when_full: assert property (@(posedge aclk) disable iff (!rst_n_i)
        wr_req_o |-> count_q != DEPTH);

endmodule

// ==== logic/event_mem_arbiter.sv ====
`timescale 1ns/1ns
`include "event_builder_settings.svh"

module event_mem_arbiter
    import event_builder_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n_i,
    input  link_mask_t wr_req_i,
    input  buf_addr_t  wr_addr_i [`EB_NUM_LINKS],
    input  data_t      wr_data_i [`EB_NUM_LINKS],
    output link_mask_t wr_gnt_o,
    input  logic       rd_req_i,
    input  buf_addr_t  rd_addr_i,
    output logic       rd_gnt_o,
    output logic       mem_we_o,
    output buf_addr_t  mem_waddr_o,
    output data_t      mem_wdata_o,
    output logic       mem_re_o,
    output buf_addr_t  mem_raddr_o
);

    // writers take slots 0 to 3 and the readout takes the last one
    localparam int NUM_REQ = `EB_NUM_LINKS + 1;

    logic [NUM_REQ-1:0] req_all;
    logic [NUM_REQ-1:0] gnt_all;
    logic [2:0]         win_idx;
    logic               any_gnt;
    logic [2:0]         ptr_q;
    logic [2:0]         wait_q [NUM_REQ];

    assign req_all = {rd_req_i, wr_req_i};

    // search starts at the pointer and wraps around
    always_comb begin : pick
        logic [2:0] slot;
        gnt_all = '0;
        win_idx = '0;
        any_gnt = 1'b0;
        for (int i = 0; i < NUM_REQ; i++) begin
            slot = 3'((int'(ptr_q) + i) % NUM_REQ);
            if (!any_gnt && req_all[slot]) begin
                any_gnt = 1'b1;
                win_idx = slot;
            end
        end
        if (any_gnt) begin
            gnt_all[win_idx] = 1'b1;
        end
    end

    // winner drops to lowest priority for the next round
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (any_gnt) begin
            ptr_q <= (win_idx == 3'(NUM_REQ - 1)) ? '0 : win_idx + 1'b1;
        end
    end

    // cycles each slot has spent asking without a grant
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < NUM_REQ; r++) begin
                wait_q[r] <= '0;
            end
        end else begin
            for (int r = 0; r < NUM_REQ; r++) begin
                wait_q[r] <= (req_all[r] && !gnt_all[r]) ? wait_q[r] + 1'b1 : '0;
            end
        end
    end

    assign wr_gnt_o = gnt_all[`EB_NUM_LINKS-1:0];
    assign rd_gnt_o = gnt_all[NUM_REQ-1];

    always_comb begin
        mem_waddr_o = '0;
        mem_wdata_o = '0;
        for (int l = 0; l < `EB_NUM_LINKS; l++) begin
            if (wr_gnt_o[l]) begin
                mem_waddr_o = wr_addr_i[l];
                mem_wdata_o = wr_data_i[l];
            end
        end
    end

    assign mem_we_o    = |wr_gnt_o;
    assign mem_re_o    = rd_gnt_o;
    assign mem_raddr_o = rd_addr_i;

    // a waiting requester is served within five grants
    for (genvar r = 0; r < NUM_REQ; r++) begin : g_wait
        a_req_served: assert property (@(posedge aclk) disable iff (!rst_n_i)
            wait_q[r] < 3'(NUM_REQ));
    end

endmodule

// ==== logic/event_buffer_ram.sv ====
`timescale 1ns/1ns
`include "event_builder_settings.svh"

module event_buffer_ram
    import event_builder_pkg::*;
(
    input  logic      aclk,
    input  logic      we_i,
    input  buf_addr_t waddr_i,
    input  data_t     wdata_i,
    input  logic      re_i,
    input  buf_addr_t raddr_i,
    output data_t     rdata_o
);

    localparam int DEPTH = 2 ** `EB_ADDR_W;

    // one region per link, laid out back to back
    data_t mem_q [DEPTH];

    always_ff @(posedge aclk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // read data shows up the cycle after the read enable
    always_ff @(posedge aclk) begin
        if (re_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

// ==== logic/event_readout.sv ====
`timescale 1ns/1ns
`include "event_builder_settings.svh"

module event_readout
    import event_builder_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n_i,
    input  link_mask_t  link_mask_i,
    input  link_mask_t  done_i,
    input  word_count_t count_i [`EB_NUM_LINKS],
    output logic        rd_req_o,
    output buf_addr_t   rd_addr_o,
    input  logic        rd_gnt_i,
    input  data_t       rd_data_i,
    output data_t       out_tdata_o,
    output logic        out_tvalid_o,
    output logic        out_tlast_o,
    input  logic        out_tready_i,
    output logic        complete_o,
    output logic        release_o
);

    localparam int OFF_W = `EB_ADDR_W - $bits(link_id_t);
    localparam int PAD_W = `EB_DATA_W - `EB_EVNUM_W - `EB_NUM_LINKS;

    readout_state_t state_q;
    link_mask_t     mask_q;
    link_id_t       cur_link_q;
    word_count_t    off_q;
    evnum_t         evnum_q;
    logic           complete_q;
    logic           release_q;
    logic           out_valid_q;
    data_t          out_data_q;
    logic           out_last_q;
    logic           last_pending_q;
    logic           all_done;
    logic           any_data;
    logic           later_data;
    logic           link_has_word;
    logic           out_xfer;
    data_t          header;

    // masked links count as finished
    assign all_done = &(done_i | link_mask_i);

    assign out_xfer      = out_valid_q && out_tready_i;
    assign link_has_word = !mask_q[cur_link_q] && (off_q < count_i[cur_link_q]);
    assign header        = {evnum_q, {PAD_W{1'b0}}, mask_q};

    // looks ahead for data so the final word can carry last
    always_comb begin
        any_data   = 1'b0;
        later_data = 1'b0;
        for (int l = 0; l < `EB_NUM_LINKS; l++) begin
            if (!mask_q[l] && count_i[l] != '0) begin
                any_data = 1'b1;
                if (l > int'(cur_link_q)) begin
                    later_data = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= RO_WAIT;
            mask_q      <= '0;
            cur_link_q  <= '0;
            off_q       <= '0;
            evnum_q     <= '0;
            complete_q  <= 1'b0;
            release_q   <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            complete_q <= 1'b0;
            release_q  <= out_xfer && out_last_q;
            if (out_xfer) begin
                out_valid_q <= 1'b0;
            end
            if (out_xfer && out_last_q) begin
                evnum_q <= evnum_q + 1'b1;
            end
            case (state_q)
                RO_WAIT: begin
                    // done bits are still up during the release cycle
                    if (complete_q) begin
                        state_q <= RO_HEADER;
                    end else if (all_done && !release_q) begin
                        complete_q <= 1'b1;
                        mask_q     <= link_mask_i;
                    end
                end
                RO_HEADER: begin
                    out_valid_q <= 1'b1;
                    cur_link_q  <= '0;
                    off_q       <= '0;
                    state_q     <= any_data ? RO_REQUEST : RO_RELEASE;
                end
                RO_REQUEST: begin
                    if (!link_has_word) begin
                        cur_link_q <= cur_link_q + 1'b1;
                        off_q      <= '0;
                    end else if (rd_gnt_i) begin
                        off_q   <= off_q + 1'b1;
                        state_q <= RO_STREAM;
                    end
                end
                RO_STREAM: begin
                    out_valid_q <= 1'b1;
                    state_q     <= last_pending_q ? RO_RELEASE : RO_REQUEST;
                end
                RO_RELEASE: begin
                    if (out_xfer && out_last_q) begin
                        state_q <= RO_WAIT;
                    end
                end
                default: state_q <= RO_WAIT;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_gnt_i) begin
            last_pending_q <= (word_count_t'(off_q + 1'b1) == count_i[cur_link_q]) && !later_data;
        end
        if (state_q == RO_HEADER) begin
            out_data_q <= header;
            out_last_q <= !any_data;
        end else if (state_q == RO_STREAM) begin
            out_data_q <= rd_data_i;
            out_last_q <= last_pending_q;
        end
    end

    // reads only go out while the output register is empty
    assign rd_req_o  = (state_q == RO_REQUEST) && link_has_word && !out_valid_q;
    assign rd_addr_o = {cur_link_q, off_q[OFF_W-1:0]};

    assign out_tdata_o  = out_data_q;
    assign out_tvalid_o = out_valid_q;
    assign out_tlast_o  = out_last_q;
    assign complete_o   = complete_q;
    assign release_o    = release_q;

    a_out_stable: assert property (@(posedge aclk) disable iff (!rst_n_i)
        out_tvalid_o && !out_tready_i |=>
            out_tvalid_o && $stable(out_tdata_o) && $stable(out_tlast_o));

endmodule

// ==== logic/event_builder_top.sv ====
`timescale 1ns/1ns
`include "event_builder_settings.svh"

module event_builder_top
    import event_builder_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n_i,
    input  logic       event_open_i,
    input  link_mask_t link_mask_i,
    input  data_t      link_tdata_i [`EB_NUM_LINKS],
    input  link_mask_t link_tvalid_i,
    input  link_mask_t link_tlast_i,
    output link_mask_t link_tready_o,
    output data_t      out_tdata_o,
    output logic       out_tvalid_o,
    output logic       out_tlast_o,
    input  logic       out_tready_i,
    output logic       evin_complete_o,
    output link_mask_t err_o
);

    link_mask_t  wr_req;
    buf_addr_t   wr_addr [`EB_NUM_LINKS];
    data_t       wr_data [`EB_NUM_LINKS];
    link_mask_t  wr_gnt;
    link_mask_t  done;
    word_count_t count [`EB_NUM_LINKS];
    logic        rd_req;
    buf_addr_t   rd_addr;
    logic        rd_gnt;
    data_t       rd_data;
    logic        mem_we;
    buf_addr_t   mem_waddr;
    data_t       mem_wdata;
    logic        mem_re;
    buf_addr_t   mem_raddr;
    logic        release_pulse;

    for (genvar l = 0; l < `EB_NUM_LINKS; l++) begin : g_link
        link_event_writer #(
            .LINK_ID(l)
        ) u_writer (
            .aclk         (aclk),
            .rst_n_i      (rst_n_i),
            .event_open_i (event_open_i),
            .s_tdata_i    (link_tdata_i[l]),
            .s_tvalid_i   (link_tvalid_i[l]),
            .s_tlast_i    (link_tlast_i[l]),
            .s_tready_o   (link_tready_o[l]),
            .wr_req_o     (wr_req[l]),
            .wr_addr_o    (wr_addr[l]),
            .wr_data_o    (wr_data[l]),
            .wr_gnt_i     (wr_gnt[l]),
            .release_i    (release_pulse),
            .done_o       (done[l]),
            .count_o      (count[l]),
            .overflow_o   (err_o[l])
        );
    end

    event_mem_arbiter u_arbiter (
        .aclk        (aclk),
        .rst_n_i     (rst_n_i),
        .wr_req_i    (wr_req),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .wr_gnt_o    (wr_gnt),
        .rd_req_i    (rd_req),
        .rd_addr_i   (rd_addr),
        .rd_gnt_o    (rd_gnt),
        .mem_we_o    (mem_we),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata),
        .mem_re_o    (mem_re),
        .mem_raddr_o (mem_raddr)
    );

    event_buffer_ram u_buffer (
        .aclk    (aclk),
        .we_i    (mem_we),
        .waddr_i (mem_waddr),
        .wdata_i (mem_wdata),
        .re_i    (mem_re),
        .raddr_i (mem_raddr),
        .rdata_o (rd_data)
    );

    event_readout u_readout (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .link_mask_i  (link_mask_i),
        .done_i       (done),
        .count_i      (count),
        .rd_req_o     (rd_req),
        .rd_addr_o    (rd_addr),
        .rd_gnt_i     (rd_gnt),
        .rd_data_i    (rd_data),
        .out_tdata_o  (out_tdata_o),
        .out_tvalid_o (out_tvalid_o),
        .out_tlast_o  (out_tlast_o),
        .out_tready_i (out_tready_i),
        .complete_o   (evin_complete_o),
        .release_o    (release_pulse)
    );

endmodule

// ==== verification/event_builder_tb.sv ====
`timescale 1ns/1ns
`include "event_builder_settings.svh"

module event_builder_tb
    import event_builder_pkg::*;
();

    localparam int NUM_TESTS   = 6;
    localparam int MAX_FRAG    = 80;
    // cycles one event may take before it counts as stuck
    localparam int EVENT_LIMIT = 1500;
    localparam int PAD_W       = `EB_DATA_W - `EB_EVNUM_W - `EB_NUM_LINKS;

    logic       aclk;
    logic       rst_n_i;
    logic       event_open_i;
    link_mask_t link_mask_i;
    data_t      link_tdata_i [`EB_NUM_LINKS];
    link_mask_t link_tvalid_i;
    link_mask_t link_tlast_i;
    link_mask_t link_tready_o;
    data_t      out_tdata_o;
    logic       out_tvalid_o;
    logic       out_tlast_o;
    logic       out_tready_i;
    logic       evin_complete_o;
    link_mask_t err_o;

    data_t  frag_data [`EB_NUM_LINKS][MAX_FRAG];
    int     frag_len [`EB_NUM_LINKS];
    data_t  exp_data [$];
    logic   exp_last [$];
    evnum_t hdr_evnums [$];
    evnum_t next_evnum;
    int     errors;
    int     tests_failed;
    int     complete_cnt;
    logic   ready_random;
    logic   at_header;

    event_builder_top dut0 (
        .aclk            (aclk),
        .rst_n_i         (rst_n_i),
        .event_open_i    (event_open_i),
        .link_mask_i     (link_mask_i),
        .link_tdata_i    (link_tdata_i),
        .link_tvalid_i   (link_tvalid_i),
        .link_tlast_i    (link_tlast_i),
        .link_tready_o   (link_tready_o),
        .out_tdata_o     (out_tdata_o),
        .out_tvalid_o    (out_tvalid_o),
        .out_tlast_o     (out_tlast_o),
        .out_tready_i    (out_tready_i),
        .evin_complete_o (evin_complete_o),
        .err_o           (err_o)
    );

    always #5 aclk = ~aclk;

    // header, then every unmasked fragment in link order, cut at the region depth
    function automatic void build_expected(input evnum_t evnum, input link_mask_t mask);
        int n;
        exp_data.push_back({evnum, {PAD_W{1'b0}}, mask});
        exp_last.push_back(1'b0);
        for (int l = 0; l < `EB_NUM_LINKS; l++) begin
            if (!mask[l]) begin
                n = (frag_len[l] > `EB_REGION_DEPTH) ? `EB_REGION_DEPTH : frag_len[l];
                for (int i = 0; i < n; i++) begin
                    exp_data.push_back(frag_data[l][i]);
                    exp_last.push_back(1'b0);
                end
            end
        end
        exp_last[exp_last.size()-1] = 1'b1;
    endfunction

    // every transferred output word is checked against the expected queue
    always @(posedge aclk) begin
        data_t want_data;
        logic  want_last;
        if (rst_n_i && out_tvalid_o && out_tready_i) begin
            if (at_header) begin
                hdr_evnums.push_back(out_tdata_o[`EB_DATA_W-1 -: `EB_EVNUM_W]);
            end
            at_header = out_tlast_o;
            assert (exp_data.size() != 0) else begin
                $display("%0t ns: output word %h arrived when no word was expected",
                         $time, out_tdata_o);
                errors++;
            end
            if (exp_data.size() != 0) begin
                want_data = exp_data.pop_front();
                want_last = exp_last.pop_front();
                assert (out_tdata_o === want_data) else begin
                    $display("MISMATCH at %0t ns: out_tdata_o got %h expected %h",
                             $time, out_tdata_o, want_data);
                    errors++;
                end
                assert (out_tlast_o === want_last) else begin
                    $display("MISMATCH at %0t ns: out_tlast_o got %b expected %b",
                             $time, out_tlast_o, want_last);
                    errors++;
                end
            end
        end
    end

    always @(posedge aclk) begin
        if (rst_n_i && evin_complete_o) begin
            complete_cnt++;
        end
    end

    always @(posedge aclk) begin
        if (ready_random) begin
            out_tready_i <= 1'($urandom_range(1, 0));
        end else begin
            out_tready_i <= 1'b1;
        end
    end

    task automatic make_fragments(input int min_len, input int max_len);
        for (int l = 0; l < `EB_NUM_LINKS; l++) begin
            frag_len[l] = int'($urandom_range(max_len, min_len));
            for (int i = 0; i < MAX_FRAG; i++) begin
                frag_data[l][i] = $urandom();
            end
        end
    endtask

    // all unmasked links stream in parallel, one word per handshake
    task automatic send_fragments(input link_mask_t mask);
        int idx [`EB_NUM_LINKS];
        bit busy;
        for (int l = 0; l < `EB_NUM_LINKS; l++) begin
            idx[l] = 0;
            link_tvalid_i[l] <= !mask[l];
            link_tdata_i[l]  <= frag_data[l][0];
            link_tlast_i[l]  <= (frag_len[l] == 1);
        end
        busy = 1'b1;
        while (busy) begin
            @(posedge aclk);
            busy = 1'b0;
            for (int l = 0; l < `EB_NUM_LINKS; l++) begin
                if (!mask[l] && idx[l] < frag_len[l]) begin
                    if (link_tvalid_i[l] && link_tready_o[l]) begin
                        idx[l]++;
                    end
                    if (idx[l] < frag_len[l]) begin
                        link_tdata_i[l] <= frag_data[l][idx[l]];
                        link_tlast_i[l] <= (idx[l] == frag_len[l] - 1);
                        busy = 1'b1;
                    end else begin
                        link_tvalid_i[l] <= 1'b0;
                    end
                end
            end
        end
    endtask

    task automatic run_event(input link_mask_t mask);
        int waited;
        complete_cnt = 0;
        link_mask_i <= mask;
        build_expected(next_evnum, mask);
        next_evnum++;
        send_fragments(mask);
        waited = 0;
        while (exp_data.size() != 0 && waited < EVENT_LIMIT) begin
            @(posedge aclk);
            waited++;
        end
        assert (exp_data.size() == 0) else begin
            $display("%0t ns: event timed out with %0d output words still missing",
                     $time, exp_data.size());
            errors++;
            exp_data.delete();
            exp_last.delete();
        end
        // let release reach the writers before the next event
        repeat (3) @(posedge aclk);
        assert (complete_cnt == 1) else begin
            $display("%0t ns: evin_complete_o pulsed %0d times for one event",
                     $time, complete_cnt);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_start);
            tests_failed++;
        end
    endtask

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge aclk);
        $display("watchdog: run did not finish within %0d cycles", NUM_TESTS * 2000);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int start;
        link_mask_t mask;
        void'($urandom(3252));
        aclk          = 1'b0;
        errors        = 0;
        tests_failed  = 0;
        complete_cnt  = 0;
        next_evnum    = '0;
        ready_random  = 1'b0;
        at_header     = 1'b1;
        rst_n_i       <= 1'b0;
        event_open_i  <= 1'b1;
        link_mask_i   <= '0;
        link_tvalid_i <= '0;
        link_tlast_i  <= '0;
        out_tready_i  <= 1'b1;
        for (int l = 0; l < `EB_NUM_LINKS; l++) begin
            link_tdata_i[l] <= '0;
        end
        repeat (10) @(posedge aclk);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge aclk);

        start = errors;
        make_fragments(1, 40);
        run_event('0);
        report_test(1, "all links enabled", start);

        start = errors;
        mask = link_mask_t'($urandom_range(14, 1));
        make_fragments(1, 40);
        run_event(mask);
        report_test(2, "random link mask", start);

        start = errors;
        ready_random = 1'b1;
        make_fragments(1, 40);
        run_event('0);
        ready_random = 1'b0;
        report_test(3, "output back-pressure", start);

        // closed interface, everything offered must be swallowed
        start = errors;
        event_open_i <= 1'b0;
        for (int c = 0; c < 20; c++) begin
            for (int l = 0; l < `EB_NUM_LINKS; l++) begin
                link_tvalid_i[l] <= 1'b1;
                link_tdata_i[l]  <= $urandom();
                link_tlast_i[l]  <= 1'($urandom_range(1, 0));
            end
            @(posedge aclk);
            assert (link_tready_o === '1) else begin
                $display("MISMATCH at %0t ns: link_tready_o got %b expected 1111",
                         $time, link_tready_o);
                errors++;
            end
        end
        link_tvalid_i <= '0;
        event_open_i  <= 1'b1;
        @(posedge aclk);
        make_fragments(1, 40);
        run_event('0);
        report_test(4, "closed interface", start);

        start = errors;
        make_fragments(1, 40);
        frag_len[2] = 70;
        run_event('0);
        assert (err_o === 4'b0100) else begin
            $display("MISMATCH at %0t ns: err_o got %b expected 0100", $time, err_o);
            errors++;
        end
        report_test(5, "fragment overflow", start);

        start = errors;
        make_fragments(1, 20);
        run_event('0);
        make_fragments(1, 20);
        run_event(4'b1001);
        assert (hdr_evnums.size() == int'(next_evnum)) else begin
            $display("%0t ns: saw %0d headers for %0d events", $time,
                     hdr_evnums.size(), next_evnum);
            errors++;
        end
        for (int i = 0; i < hdr_evnums.size(); i++) begin
            assert (hdr_evnums[i] == evnum_t'(i)) else begin
                $display("MISMATCH at %0t ns: header event number got %0d expected %0d",
                         $time, hdr_evnums[i], i);
                errors++;
            end
        end
        report_test(6, "event numbering", start);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d", NUM_TESTS,
                 NUM_TESTS - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+logic
logic/event_builder_pkg.sv
logic/link_event_writer.sv
logic/event_mem_arbiter.sv
logic/event_buffer_ram.sv
logic/event_readout.sv
logic/event_builder_top.sv
verification/event_builder_tb.sv

// ==== Makefile ====
# Verilator build and run for the event builder testbench

VERILATOR ?= verilator
TOP       ?= event_builder_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
LOG       ?= sim.log
VFLAGS    ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard logic/*.sv logic/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

run: compile
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qF '>>> PASS' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
